/* list.f */
logic/fp_pkg.sv
logic/fp_classify.sv
logic/fp_decode.sv
logic/fp_execute.sv
logic/fp_result.sv
logic/fp_special_top.sv
+incdir+test
test/fp_special_tb.sv

/* test/fp_special_ref.svh */
`ifndef FP_SPECIAL_REF_SVH
`define FP_SPECIAL_REF_SVH

// expected class of one operand, worked out from its fields
function automatic fp_class_e classify_ref(input logic [WORD_W-1:0] w);
    logic             s;
    logic [EXP_W-1:0] e;
    logic [MAN_W-1:0] m;
    s = w[WORD_W-1];
    e = w[WORD_W-2:MAN_W];
    m = w[MAN_W-1:0];
    if (e == '1) begin
        if (m == '0) return s ? CLS_NEG_INF : CLS_POS_INF;
        return m[MAN_W-1] ? CLS_QNAN : CLS_SNAN;
    end
    if (e == '0) begin
        if (m == '0) return s ? CLS_NEG_ZERO : CLS_POS_ZERO;
        return s ? CLS_NEG_SUB : CLS_POS_SUB;
    end
    return s ? CLS_NEG_NORM : CLS_POS_NORM;
endfunction

function automatic logic class_is_nan(input fp_class_e c);
    return (c == CLS_SNAN) || (c == CLS_QNAN);
endfunction

function automatic logic class_is_inf(input fp_class_e c);
    return (c == CLS_POS_INF) || (c == CLS_NEG_INF);
endfunction

function automatic logic class_is_zero(input fp_class_e c);
    return (c == CLS_POS_ZERO) || (c == CLS_NEG_ZERO);
endfunction

function automatic logic [WORD_W-1:0] signed_inf(input logic s);
    return {s, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
endfunction

function automatic logic [WORD_W-1:0] signed_zero(input logic s);
    return {s, {(EXP_W + MAN_W){1'b0}}};
endfunction

// expected result word and flags for one request
function automatic void expected_outcome(
    input  fp_op_e            op,
    input  logic [WORD_W-1:0] a,
    input  logic [WORD_W-1:0] b,
    output logic [WORD_W-1:0] res,
    output logic              nv,
    output logic              dz,
    output logic              gen
);
    fp_class_e         ca;
    fp_class_e         cb;
    logic              sa;
    logic              sb_eff;
    logic              sx;
    logic [WORD_W-1:0] qnan;
    ca     = classify_ref(a);
    cb     = classify_ref(b);
    sa     = a[WORD_W-1];
    sb_eff = b[WORD_W-1] ^ (op == OP_SUB);
    sx     = a[WORD_W-1] ^ b[WORD_W-1];
    qnan   = {1'b0, {EXP_W{1'b1}}, 1'b1, {(MAN_W - 1){1'b0}}};
    res    = '0;
    nv     = 1'b0;
    dz     = 1'b0;
    gen    = 1'b0;
    if (op <= OP_DIV && (class_is_nan(ca) || class_is_nan(cb))) begin
        res = qnan;
        nv  = (ca == CLS_SNAN) || (cb == CLS_SNAN);
    end else if (op == OP_ADD || op == OP_SUB) begin
        if (class_is_inf(ca) && class_is_inf(cb) && sa != sb_eff) begin
            res = qnan;
            nv  = 1'b1;
        end else if (class_is_inf(ca)) res = signed_inf(sa);
        else if (class_is_inf(cb)) res = signed_inf(sb_eff);
        else if (class_is_zero(ca) && class_is_zero(cb)) res = signed_zero(sa & sb_eff);
        else if (class_is_zero(ca)) res = {sb_eff, b[WORD_W-2:0]};
        else if (class_is_zero(cb)) res = a;
        else gen = 1'b1;
    end else if (op == OP_MUL) begin
        if ((class_is_inf(ca) || class_is_inf(cb))
            && (class_is_zero(ca) || class_is_zero(cb))) begin
            res = qnan;
            nv  = 1'b1;
        end else if (class_is_inf(ca) || class_is_inf(cb)) res = signed_inf(sx);
        else if (class_is_zero(ca) || class_is_zero(cb)) res = signed_zero(sx);
        else gen = 1'b1;
    end else if (op == OP_DIV) begin
        if ((class_is_zero(ca) && class_is_zero(cb))
            || (class_is_inf(ca) && class_is_inf(cb))) begin
            res = qnan;
            nv  = 1'b1;
        end else if (class_is_zero(cb)) begin
            res = signed_inf(sx);
            dz  = 1'b1;
        end else if (class_is_inf(ca)) res = signed_inf(sx);
        else if (class_is_zero(ca) || class_is_inf(cb)) res = signed_zero(sx);
        else gen = 1'b1;
    end else if (op == OP_SQRT) begin
        if (class_is_nan(ca)) begin
            res = qnan;
            nv  = (ca == CLS_SNAN);
        end else if (sa && !class_is_zero(ca)) begin
            res = qnan;
            nv  = 1'b1;
        end else if (class_is_zero(ca) || ca == CLS_POS_INF) res = a;
        else gen = 1'b1;
    end else begin
        // class query, spare codes too
        res = WORD_W'(1) << ca;
    end
endfunction

`endif

/* test/fp_special_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_special_tb
    import fp_pkg::*;
();

    localparam int EXP_W          = 8;
    localparam int MAN_W          = 23;
    localparam int WORD_W         = 1 + EXP_W + MAN_W;
    localparam int RESET_CYCLES   = 16;
    localparam int N_SPECIAL      = 12;
    localparam int N_REQUESTS     = 300;
    localparam int N_RANDOM       = N_REQUESTS - 2 * N_SPECIAL - N_SPECIAL * N_SPECIAL;
    localparam int TIMEOUT_CYCLES = N_REQUESTS * 8 + RESET_CYCLES + 200;

    typedef struct packed {
        fp_op_e            op;
        fp_class_e         cls;
        logic [WORD_W-1:0] res;
        logic              nv;
        logic              dz;
        logic              gen;
    } outcome_t;

    logic              clk = 1'b0;
    logic              i_reset;
    logic              i_req;
    fp_op_e            i_op;
    logic [WORD_W-1:0] i_a;
    logic [WORD_W-1:0] i_b;
    logic              o_ack;
    logic [WORD_W-1:0] o_result;
    logic              o_nv;
    logic              o_dz;
    logic              o_general;

    outcome_t expect_q[$];
    outcome_t cur;
    int       n_checked   = 0;
    int       cycle_count = 0;
    logic     ack_seen    = 1'b0;

    `include "fp_special_ref.svh"

    fp_special_top #(.EXP_W(EXP_W), .MAN_W(MAN_W)) dut_i (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_req     (i_req),
        .i_op      (i_op),
        .i_a       (i_a),
        .i_b       (i_b),
        .o_ack     (o_ack),
        .o_result  (o_result),
        .o_nv      (o_nv),
        .o_dz      (o_dz),
        .o_general (o_general)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] expected,
                              input logic [WORD_W-1:0] actual);
        if (actual !== expected)
            abort_run($sformatf("Fail: time %0t, %s expected %h got %h",
                                $time, name, expected, actual));
    endtask

    task automatic check_class(input fp_class_e expected, input logic [NUM_CLASSES-1:0] actual);
        logic [NUM_CLASSES-1:0] mask;
        mask = NUM_CLASSES'(1) << expected;
        if (actual !== mask)
            abort_run($sformatf("Fail: time %0t, o_result class mask expected %b (%s) got %b",
                                $time, mask, expected.name(), actual));
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            abort_run($sformatf("Fail: time %0t, %s expected %b got %b",
                                $time, name, expected, actual));
    endtask

    // directed operands, one or two of every class
    function automatic logic [WORD_W-1:0] special_value(input int idx);
        case (idx)
            0: return 32'h0000_0000;
            1: return 32'h8000_0000;
            2: return 32'h0000_0001;
            3: return 32'h807F_FFFF;
            4: return 32'h3F80_0000;
            5: return 32'hC040_0000;
            6: return 32'h7F80_0000;
            7: return 32'hFF80_0000;
            8: return 32'h7F80_0001;
            9: return 32'h7FC0_0000;
            10: return 32'hFFA0_0000;
            default: return 32'hFFFF_FFFF;
        endcase
    endfunction

    // half the random operands are specials, so the rules get hit often
    function automatic logic [WORD_W-1:0] pick_operand();
        if ($urandom_range(0, 1) == 0) return special_value($urandom_range(0, N_SPECIAL - 1));
        return $urandom();
    endfunction

    // one full four-phase transfer, ending with o_ack low again
    task automatic run_request(input fp_op_e op, input logic [WORD_W-1:0] a,
                               input logic [WORD_W-1:0] b);
        outcome_t exp;
        int       waited;
        exp.op  = op;
        exp.cls = classify_ref(a);
        expected_outcome(op, a, b, exp.res, exp.nv, exp.dz, exp.gen);
        expect_q.push_back(exp);
        i_op   = op;
        i_a    = a;
        i_b    = b;
        i_req  = 1'b1;
        waited = 0;
        while (o_ack !== 1'b1 && waited < 8) begin
            @(posedge clk);
            #5;
            waited++;
        end
        // ack is due on the third edge counting the one that samples i_req
        if (o_ack !== 1'b1) abort_run("o_ack never rose for a pending request");
        else if (waited != 3)
            abort_run($sformatf("o_ack rose on edge %0d after i_req was raised, expected edge 3",
                                waited));
        i_req = 1'b0;
        @(posedge clk);
        #5;
        if (o_ack !== 1'b0) abort_run("o_ack did not fall on the edge that sampled i_req low");
    endtask

    // compare on each rising o_ack, half a cycle after it settles
    always @(negedge clk) begin
        if (!i_reset && o_ack === 1'b1 && ack_seen !== 1'b1) begin
            if (expect_q.size() == 0) begin
                abort_run("o_ack rose with no request outstanding");
            end else begin
                cur = expect_q.pop_front();
                if (cur.op >= OP_CLASS) check_class(cur.cls, o_result[NUM_CLASSES-1:0]);
                check_word("o_result", cur.res, o_result);
                check_flag("o_nv", cur.nv, o_nv);
                check_flag("o_dz", cur.dz, o_dz);
                check_flag("o_general", cur.gen, o_general);
                n_checked++;
            end
        end
        ack_seen = o_ack;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run($sformatf("timeout after %0d cycles", cycle_count));
    end

    initial begin
        int                i;
        fp_op_e            op;
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        void'($urandom(32'h296));
        i_reset = 1'b1;
        i_req   = 1'b0;
        i_op    = OP_ADD;
        i_a     = '0;
        i_b     = '0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #5;
            if (o_ack !== 1'b0) abort_run("o_ack was not low during reset");
        end
        i_reset = 1'b0;
        for (i = 0; i < N_SPECIAL; i++) begin
            run_request(OP_CLASS, special_value(i), special_value(N_SPECIAL - 1 - i));
            run_request(OP_SQRT, special_value(i), '0);
        end
        // every pair of specials, the binary op rotating across pairs
        for (i = 0; i < N_SPECIAL * N_SPECIAL; i++) begin
            op = fp_op_e'((i + i / N_SPECIAL) % 4);
            run_request(op, special_value(i % N_SPECIAL), special_value(i / N_SPECIAL));
        end
        for (i = 0; i < N_RANDOM; i++) begin
            op = fp_op_e'($urandom_range(0, 7));
            a  = pick_operand();
            b  = pick_operand();
            run_request(op, a, b);
        end
        @(negedge clk);
        if (n_checked == N_REQUESTS && expect_q.size() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            abort_run($sformatf("only %0d of %0d results were compared",
                                n_checked, N_REQUESTS));
        end
    end

endmodule

`default_nettype wire

/* logic/fp_special_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_special_top
    import fp_pkg::*;
#(
    parameter int EXP_W = 8,
    parameter int MAN_W = 23
) (
    input  wire logic                 clk,
    input  wire logic                 i_reset,
    input  wire logic                 i_req,
    input  wire fp_op_e               i_op,
    input  wire logic [EXP_W+MAN_W:0] i_a,
    input  wire logic [EXP_W+MAN_W:0] i_b,
    output logic                      o_ack,
    output logic      [EXP_W+MAN_W:0] o_result,
    output logic                      o_nv,
    output logic                      o_dz,
    output logic                      o_general
);

    // decode to execute
    logic                 dec_valid;
    fp_op_e               dec_op;
    logic [EXP_W+MAN_W:0] dec_a;
    logic [EXP_W+MAN_W:0] dec_b;
    fp_class_e            dec_cls_a;
    fp_class_e            dec_cls_b;

    // execute to result
    logic                 exe_valid;
    logic [EXP_W+MAN_W:0] exe_result;
    logic                 exe_nv;
    logic                 exe_dz;
    logic                 exe_general;

    fp_decode #(.EXP_W(EXP_W), .MAN_W(MAN_W)) decode_i (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_req    (i_req),
        .i_op     (i_op),
        .i_a      (i_a),
        .i_b      (i_b),
        .o_valid  (dec_valid),
        .o_op     (dec_op),
        .o_a      (dec_a),
        .o_b      (dec_b),
        .o_cls_a  (dec_cls_a),
        .o_cls_b  (dec_cls_b)
    );

    fp_execute #(.EXP_W(EXP_W), .MAN_W(MAN_W)) execute_i (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_valid   (dec_valid),
        .i_op      (dec_op),
        .i_a       (dec_a),
        .i_b       (dec_b),
        .i_cls_a   (dec_cls_a),
        .i_cls_b   (dec_cls_b),
        .o_valid   (exe_valid),
        .o_result  (exe_result),
        .o_nv      (exe_nv),
        .o_dz      (exe_dz),
        .o_general (exe_general)
    );

    fp_result #(.EXP_W(EXP_W), .MAN_W(MAN_W)) result_i (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_req     (i_req),
        .i_valid   (exe_valid),
        .i_result  (exe_result),
        .i_nv      (exe_nv),
        .i_dz      (exe_dz),
        .i_general (exe_general),
        .o_ack     (o_ack),
        .o_result  (o_result),
        .o_nv      (o_nv),
        .o_dz      (o_dz),
        .o_general (o_general)
    );

endmodule

`default_nettype wire

/* logic/fp_result.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_result #(
    parameter int EXP_W = 8,
    parameter int MAN_W = 23
) (
    input  wire logic                 clk,
    input  wire logic                 i_reset,
    input  wire logic                 i_req,
    input  wire logic                 i_valid,
    input  wire logic [EXP_W+MAN_W:0] i_result,
    input  wire logic                 i_nv,
    input  wire logic                 i_dz,
    input  wire logic                 i_general,
    output logic                      o_ack,
    output logic      [EXP_W+MAN_W:0] o_result,
    output logic                      o_nv,
    output logic                      o_dz,
    output logic                      o_general
);

    // acknowledge side of the four-phase handshake
    // the requester keeps i_req high until it sees o_ack,
    // so i_valid and a low i_req never meet on the same edge
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_ack <= 1'b0;
        end else if (i_valid) begin
            o_ack <= 1'b1;
        end else if (!i_req) begin
            // requester has seen the ack and let go
            o_ack <= 1'b0;
        end
    end

    // outcome held until the next request completes,
    // so it stays readable after o_ack falls
    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_result  <= i_result;
            o_nv      <= i_nv;
            o_dz      <= i_dz;
            o_general <= i_general;
        end
    end

endmodule

`default_nettype wire

/* logic/fp_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_execute
    import fp_pkg::*;
#(
    parameter int EXP_W = 8,
    parameter int MAN_W = 23
) (
    input  wire logic                 clk,
    input  wire logic                 i_reset,
    input  wire logic                 i_valid,
    input  wire fp_op_e               i_op,
    input  wire logic [EXP_W+MAN_W:0] i_a,
    input  wire logic [EXP_W+MAN_W:0] i_b,
    input  wire fp_class_e            i_cls_a,
    input  wire fp_class_e            i_cls_b,
    output logic                      o_valid,
    output logic      [EXP_W+MAN_W:0] o_result,
    output logic                      o_nv,
    output logic                      o_dz,
    output logic                      o_general
);

    localparam int WORD_W = 1 + EXP_W + MAN_W;

    // canonical quiet NaN: positive, quiet bit only
    localparam logic [WORD_W-1:0] QNAN = {1'b0, {EXP_W{1'b1}}, 1'b1, {(MAN_W-1){1'b0}}};

    function automatic logic [WORD_W-1:0] inf_word(input logic sign);
        return {sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
    endfunction

    function automatic logic [WORD_W-1:0] zero_word(input logic sign);
        return {sign, {(EXP_W+MAN_W){1'b0}}};
    endfunction

    // operand properties from the decoded classes
    logic a_nan, a_snan, a_inf, a_zero;
    logic b_nan, b_snan, b_inf, b_zero;
    logic a_sign, b_eff_sign, prod_sign;
    logic [WORD_W-1:0] b_eff;
    logic [NUM_CLASSES-1:0] cls_mask;

    logic [WORD_W-1:0] res_c;
    logic              nv_c;
    logic              dz_c;
    logic              gen_c;

    assign a_snan = (i_cls_a == CLS_SNAN);
    assign a_nan  = a_snan || (i_cls_a == CLS_QNAN);
    assign a_inf  = (i_cls_a == CLS_NEG_INF) || (i_cls_a == CLS_POS_INF);
    assign a_zero = (i_cls_a == CLS_NEG_ZERO) || (i_cls_a == CLS_POS_ZERO);
    assign b_snan = (i_cls_b == CLS_SNAN);
    assign b_nan  = b_snan || (i_cls_b == CLS_QNAN);
    assign b_inf  = (i_cls_b == CLS_NEG_INF) || (i_cls_b == CLS_POS_INF);
    assign b_zero = (i_cls_b == CLS_NEG_ZERO) || (i_cls_b == CLS_POS_ZERO);

    // subtract is an add with b negated
    assign a_sign     = i_a[WORD_W-1];
    assign b_eff_sign = i_b[WORD_W-1] ^ (i_op == OP_SUB);
    assign b_eff      = {b_eff_sign, i_b[WORD_W-2:0]};
    assign prod_sign  = a_sign ^ i_b[WORD_W-1];

    assign cls_mask = NUM_CLASSES'(1) << i_cls_a;

    always_comb begin
        res_c = '0;
        nv_c  = 1'b0;
        dz_c  = 1'b0;
        gen_c = 1'b0;
        case (i_op)
            OP_ADD, OP_SUB: begin
                if (a_nan || b_nan) begin
                    res_c = QNAN;
                    nv_c  = a_snan || b_snan;
                end else if (a_inf && b_inf && (a_sign != b_eff_sign)) begin
                    // inf - inf
                    res_c = QNAN;
                    nv_c  = 1'b1;
                end else if (a_inf) begin
                    res_c = i_a;
                end else if (b_inf) begin
                    res_c = b_eff;
                end else if (a_zero && b_zero) begin
                    // round to nearest: -0 only when both are -0
                    res_c = zero_word(a_sign && b_eff_sign);
                end else if (a_zero) begin
                    res_c = b_eff;
                end else if (b_zero) begin
                    res_c = i_a;
                end else begin
                    gen_c = 1'b1;
                end
            end
            OP_MUL: begin
                if (a_nan || b_nan) begin
                    res_c = QNAN;
                    nv_c  = a_snan || b_snan;
                end else if ((a_zero && b_inf) || (a_inf && b_zero)) begin
                    res_c = QNAN;
                    nv_c  = 1'b1;
                end else if (a_inf || b_inf) begin
                    res_c = inf_word(prod_sign);
                end else if (a_zero || b_zero) begin
                    res_c = zero_word(prod_sign);
                end else begin
                    gen_c = 1'b1;
                end
            end
            OP_DIV: begin
                if (a_nan || b_nan) begin
                    res_c = QNAN;
                    nv_c  = a_snan || b_snan;
                end else if ((a_zero && b_zero) || (a_inf && b_inf)) begin
                    res_c = QNAN;
                    nv_c  = 1'b1;
                end else if (b_zero) begin
                    // a is nonzero here, finite or infinite
                    res_c = inf_word(prod_sign);
                    dz_c  = 1'b1;
                end else if (a_inf) begin
                    res_c = inf_word(prod_sign);
                end else if (a_zero || b_inf) begin
                    res_c = zero_word(prod_sign);
                end else begin
                    gen_c = 1'b1;
                end
            end
            OP_SQRT: begin
                if (a_nan) begin
                    res_c = QNAN;
                    nv_c  = a_snan;
                end else if (a_sign && !a_zero) begin
                    // negative operand, -inf included
                    res_c = QNAN;
                    nv_c  = 1'b1;
                end else if (a_zero || a_inf) begin
                    res_c = i_a;
                end else begin
                    gen_c = 1'b1;
                end
            end
            default: begin
                // class query and spare codes
                res_c = {{(WORD_W-NUM_CLASSES){1'b0}}, cls_mask};
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_result  <= res_c;
            o_nv      <= nv_c;
            o_dz      <= dz_c;
            o_general <= gen_c;
        end
    end

endmodule

`default_nettype wire

/* logic/fp_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_decode
    import fp_pkg::*;
#(
    parameter int EXP_W = 8,
    parameter int MAN_W = 23
) (
    input  wire logic                 clk,
    input  wire logic                 i_reset,
    input  wire logic                 i_req,
    input  wire fp_op_e               i_op,
    input  wire logic [EXP_W+MAN_W:0] i_a,
    input  wire logic [EXP_W+MAN_W:0] i_b,
    output logic                      o_valid,
    output fp_op_e                    o_op,
    output logic      [EXP_W+MAN_W:0] o_a,
    output logic      [EXP_W+MAN_W:0] o_b,
    output fp_class_e                 o_cls_a,
    output fp_class_e                 o_cls_b
);

    fp_state_e state;
    fp_class_e cls_a;
    fp_class_e cls_b;
    logic      accept;

    // classify straight off the request inputs, held stable by the requester
    fp_classify #(.EXP_W(EXP_W), .MAN_W(MAN_W)) cls_a_i (
        .i_value (i_a),
        .o_cls   (cls_a)
    );

    fp_classify #(.EXP_W(EXP_W), .MAN_W(MAN_W)) cls_b_i (
        .i_value (i_b),
        .o_cls   (cls_b)
    );

    assign accept = (state == ST_IDLE) && i_req;

    // handshake FSM
    always_ff @(posedge clk) begin
        if (i_reset) begin
            state   <= ST_IDLE;
            o_valid <= 1'b0;
        end else begin
            o_valid <= accept;
            case (state)
                ST_IDLE: begin
                    if (i_req) begin
                        state <= ST_WAIT_DROP;
                    end
                end
                ST_WAIT_DROP: begin
                    // hold off until the requester lets go
                    if (!i_req) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request capture
    always_ff @(posedge clk) begin
        if (accept) begin
            o_op    <= i_op;
            o_a     <= i_a;
            o_b     <= i_b;
            o_cls_a <= cls_a;
            o_cls_b <= cls_b;
        end
    end

endmodule

`default_nettype wire

/* logic/fp_classify.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_classify
    import fp_pkg::*;
#(
    parameter int EXP_W = 8,
    parameter int MAN_W = 23
) (
    input  wire logic [EXP_W+MAN_W:0] i_value,
    output fp_class_e                 o_cls
);

    localparam int WORD_W = 1 + EXP_W + MAN_W;

    // field split
    logic             sign;
    logic [EXP_W-1:0] exp_f;
    logic [MAN_W-1:0] man_f;

    // field tests
    logic exp_ones;
    logic exp_zero;
    logic man_zero;
    logic man_top;

    assign sign  = i_value[WORD_W-1];
    assign exp_f = i_value[WORD_W-2:MAN_W];
    assign man_f = i_value[MAN_W-1:0];

    assign exp_ones = &exp_f;
    assign exp_zero = ~|exp_f;
    assign man_zero = ~|man_f;
    // quiet bit of a NaN
    assign man_top  = man_f[MAN_W-1];

    always_comb begin
        if (exp_ones) begin
            // special exponent: infinity or NaN
            if (man_zero) begin
                if (sign) begin
                    o_cls = CLS_NEG_INF;
                end else begin
                    o_cls = CLS_POS_INF;
                end
            end else if (man_top) begin
                o_cls = CLS_QNAN;
            end else begin
                o_cls = CLS_SNAN;
            end
        end else if (exp_zero) begin
            // zero exponent: zero or subnormal
            if (man_zero) begin
                if (sign) begin
                    o_cls = CLS_NEG_ZERO;
                end else begin
                    o_cls = CLS_POS_ZERO;
                end
            end else begin
                if (sign) begin
                    o_cls = CLS_NEG_SUB;
                end else begin
                    o_cls = CLS_POS_SUB;
                end
            end
        end else begin
            // anything in between is normal
            if (sign) begin
                o_cls = CLS_NEG_NORM;
            end else begin
                o_cls = CLS_POS_NORM;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/fp_pkg.sv */
`default_nettype none

package fp_pkg;

    // number of operand classes, also the width of the class mask
    localparam int NUM_CLASSES = 10;

    // request opcodes
    // codes 6 and 7 are not named and resolve like OP_CLASS
    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_MUL   = 3'd2,
        OP_DIV   = 3'd3,
        OP_SQRT  = 3'd4,
        OP_CLASS = 3'd5
    } fp_op_e;

    // operand classes
    // the encoding doubles as the bit index in the class mask,
    // ordered from the most negative to the most positive value
    typedef enum logic [3:0] {
        // negative side
        CLS_NEG_INF  = 4'd0,
        CLS_NEG_NORM = 4'd1,
        CLS_NEG_SUB  = 4'd2,
        CLS_NEG_ZERO = 4'd3,

        // positive side
        CLS_POS_ZERO = 4'd4,
        CLS_POS_SUB  = 4'd5,
        CLS_POS_NORM = 4'd6,
        CLS_POS_INF  = 4'd7,

        // not-a-number, sign ignored
        CLS_SNAN     = 4'd8,
        CLS_QNAN     = 4'd9
    } fp_class_e;

    // request acceptance states
    // one request in flight at a time, so two states are enough
    typedef enum logic {
        // waiting for i_req to rise
        ST_IDLE      = 1'b0,
        // request taken, waiting for i_req to drop
        ST_WAIT_DROP = 1'b1
    } fp_state_e;

    // a few notes on the word layout used by all stages
    //   sign     bit  EXP_W + MAN_W
    //   exponent bits EXP_W + MAN_W - 1 down to MAN_W
    //   mantissa bits MAN_W - 1 down to 0
    // the top mantissa bit tells quiet from signalling NaN

endpackage

`default_nettype wire
